// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := bpi_ctrl_tb
FILELIST  := verilog.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir

// ==== bpi_bus_cycle.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpi_bus_cycle (
	input  wire                        CLK,
	input  wire                        local_rst,
	input  wire                        cyc_start,
	input  wire bpi_pkg::bpi_op_e      cyc_op,
	input  wire bpi_pkg::addr_t        cyc_addr,
	input  wire bpi_pkg::word_t        cyc_data,
	input  wire                        bpi_busy,
	input  wire                        bpi_load_data,
	input  wire bpi_pkg::word_t        bpi_data_from,
	output logic                       cyc_done,
	output bpi_pkg::word_t             cyc_rdata,
	output logic                       bpi_execute,
	output bpi_pkg::bpi_op_e           bpi_op,
	output bpi_pkg::addr_t             bpi_addr,
	output bpi_pkg::word_t             bpi_data_to
);
	import bpi_pkg::*;

	typedef enum logic [1:0] {
		BC_IDLE,
		BC_EXEC,
		BC_SETTLE,	// Busy not yet valid here
		BC_WAIT
	} cyc_state_e;

	cyc_state_e   state;
	logic         read_hit;
	logic         write_hit;

	assign read_hit  = (bpi_op == OP_READ) && bpi_load_data;
	assign write_hit = (bpi_op == OP_WRITE) && !bpi_busy;

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			state       <= BC_IDLE;
			bpi_execute <= 1'b0;
			cyc_done    <= 1'b0;
		end
		else
		begin
			bpi_execute <= 1'b0;
			cyc_done    <= 1'b0;
			case (state)
				BC_IDLE:
					if (cyc_start)
					begin
						bpi_execute <= 1'b1;
						state       <= BC_EXEC;
					end
				BC_EXEC:
					state <= BC_SETTLE;
				BC_SETTLE:
					if (read_hit)	// Fast read data
					begin
						cyc_done <= 1'b1;
						state    <= BC_IDLE;
					end
					else
						state <= BC_WAIT;
				default:
					if (read_hit || write_hit)
					begin
						cyc_done <= 1'b1;
						state    <= BC_IDLE;
					end
			endcase
		end
	end

	// Bus outputs held for the whole cycle
	always_ff @(posedge CLK)
	begin
		if (state == BC_IDLE && cyc_start)
		begin
			bpi_op      <= cyc_op;
			bpi_addr    <= cyc_addr;
			bpi_data_to <= cyc_data;
		end
		if ((state == BC_SETTLE || state == BC_WAIT) && read_hit)
			cyc_rdata <= bpi_data_from;
	end

endmodule

`default_nettype wire

// ==== bpi_cmd_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpi_cmd_parser (
	input  wire                      CLK,
	input  wire                      local_rst,
	input  wire                      bpi_enbl,
	input  wire                      bpi_dsbl,
	input  wire bpi_pkg::word_t      fifo_data,
	input  wire                      fifo_empty,
	input  wire                      seq_done,
	output logic                     fifo_pop,
	output logic                     seq_start,
	output bpi_pkg::bpi_cmd_e        seq_cmd,
	output bpi_pkg::addr_t           seq_addr,
	output bpi_pkg::word_t           seq_data,
	output logic                     clr_sticky
);
	import bpi_pkg::*;

	typedef enum logic [2:0] {
		P_IDLE,
		P_FETCH,
		P_EXTRA,
		P_DISPATCH,
		P_WAIT
	} parse_state_e;

	parse_state_e   state;
	logic           enabled;
	bpi_cmd_e       cmd_q;
	bpi_cmd_e       fifo_cmd;
	logic [6:0]     arg_q;	// Base address part of the argument
	logic [6:0]     base_q;
	word_t          offset_q;
	word_t          prog_q;

	assign fifo_cmd  = bpi_cmd_e'(fifo_data[4:0]);
	assign fifo_pop  = (state == P_FETCH) || ((state == P_EXTRA) && !fifo_empty);
	assign seq_start = (state == P_DISPATCH);
	assign seq_cmd   = cmd_q;
	assign seq_addr  = {base_q, offset_q};
	assign seq_data  = prog_q;

	// Enable wins over disable
	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
			enabled <= 1'b0;
		else if (bpi_enbl)
			enabled <= 1'b1;
		else if (bpi_dsbl)
			enabled <= 1'b0;
	end

	////////////////////
	// Command FSM
	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			state      <= P_IDLE;
			cmd_q      <= CMD_NOOP;
			base_q     <= '0;
			offset_q   <= '0;
			clr_sticky <= 1'b0;
		end
		else
		begin
			clr_sticky <= 1'b0;
			case (state)
				P_IDLE:
					if (enabled && !fifo_empty)
						state <= P_FETCH;	// Only new commands need enable
				P_FETCH:
				begin
					cmd_q <= fifo_cmd;
					case (fifo_cmd)
						CMD_LOAD_ADDR, CMD_PROGRAM:
							state <= P_EXTRA;
						CMD_READ_1, CMD_READ_SR, CMD_CLR_SR, CMD_BLOCK_ERASE:
							state <= P_DISPATCH;
						CMD_CLR_STATUS:
						begin
							clr_sticky <= 1'b1;
							state      <= P_IDLE;
						end
						default:
							state <= P_IDLE;	// Unused codes dropped
					endcase
				end
				P_EXTRA:
					if (!fifo_empty)	// Stall mid-command until the word arrives
					begin
						if (cmd_q == CMD_LOAD_ADDR)
						begin
							base_q   <= arg_q;
							offset_q <= fifo_data;
							state    <= P_IDLE;
						end
						else
							state <= P_DISPATCH;
					end
				P_DISPATCH:
					state <= P_WAIT;
				P_WAIT:
					if (seq_done)
					begin
						if (cmd_q == CMD_READ_1 || cmd_q == CMD_PROGRAM)
							offset_q <= offset_q + 1'b1;	// Auto-increment
						state <= P_IDLE;
					end
				default:
					state <= P_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (state == P_FETCH)
			arg_q <= fifo_data[11:5];
		if (state == P_EXTRA && !fifo_empty)
			prog_q <= fifo_data;	// Program data word
	end

endmodule

`default_nettype wire

// ==== bpi_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpi_ctrl #(
	parameter int CMD_DEPTH = 2048,
	parameter int RBK_DEPTH = 2048
) (
	input  wire                               CLK,
	input  wire                               local_rst,
	// Host side
	input  wire bpi_pkg::word_t               cmd_data,
	input  wire                               cmd_we,
	input  wire                               rbk_re,
	input  wire                               bpi_enbl,
	input  wire                               bpi_dsbl,
	output wire bpi_pkg::word_t               rbk_data,
	output wire [$clog2(RBK_DEPTH+1)-1:0]     rbk_wrd_cnt,
	output wire bpi_pkg::word_t               bpi_status,
	// Low level bus-cycle port
	input  wire                               bpi_busy,
	input  wire                               bpi_load_data,
	input  wire bpi_pkg::word_t               bpi_data_from,
	output wire                               bpi_execute,
	output wire bpi_pkg::bpi_op_e             bpi_op,
	output wire bpi_pkg::addr_t               bpi_addr,
	output wire bpi_pkg::word_t               bpi_data_to
);
	import bpi_pkg::*;

	// Command queue
	word_t      cmd_head;
	logic       cmd_pop;
	logic       cmd_empty;
	logic       cmd_full;
	logic       cmd_over;
	logic       cmd_under;

	// Readback queue
	logic       rbk_push;
	word_t      rbk_wdata;
	logic       rbk_empty;
	logic       rbk_full;
	logic       rbk_over;
	logic       rbk_under;

	////////////////////
	// Parser, sequencer and bus cycle links
	logic       seq_start;
	bpi_cmd_e   seq_cmd;
	addr_t      seq_addr;
	word_t      seq_data;
	logic       seq_done;
	logic       clr_sticky;
	logic       cyc_start;
	bpi_op_e    cyc_op;
	addr_t      cyc_addr;
	word_t      cyc_data;
	logic       cyc_done;
	word_t      cyc_rdata;
	logic       sr_load;
	logic [7:0] sr_value;

	bpi_fifo #(.DEPTH(CMD_DEPTH)) cmd_fifo (
		.CLK(CLK), .local_rst(local_rst),
		.wr_en(cmd_we), .wr_data(cmd_data), .rd_en(cmd_pop), .rd_data(cmd_head),
		.count(), .empty(cmd_empty), .full(cmd_full), .over(cmd_over), .under(cmd_under)
	);

	bpi_fifo #(.DEPTH(RBK_DEPTH)) rbk_fifo (
		.CLK(CLK), .local_rst(local_rst),
		.wr_en(rbk_push), .wr_data(rbk_wdata), .rd_en(rbk_re), .rd_data(rbk_data),
		.count(rbk_wrd_cnt), .empty(rbk_empty), .full(rbk_full), .over(rbk_over),
		.under(rbk_under)
	);

	bpi_cmd_parser cmd_parser (
		.CLK(CLK), .local_rst(local_rst), .bpi_enbl(bpi_enbl), .bpi_dsbl(bpi_dsbl),
		.fifo_data(cmd_head), .fifo_empty(cmd_empty), .seq_done(seq_done),
		.fifo_pop(cmd_pop), .seq_start(seq_start), .seq_cmd(seq_cmd), .seq_addr(seq_addr),
		.seq_data(seq_data), .clr_sticky(clr_sticky)
	);

	bpi_sequencer sequencer (
		.CLK(CLK), .local_rst(local_rst), .seq_start(seq_start), .seq_cmd(seq_cmd),
		.seq_addr(seq_addr), .seq_data(seq_data), .cyc_done(cyc_done), .cyc_rdata(cyc_rdata),
		.seq_done(seq_done), .cyc_start(cyc_start), .cyc_op(cyc_op), .cyc_addr(cyc_addr),
		.cyc_data(cyc_data), .rbk_push(rbk_push), .rbk_wdata(rbk_wdata),
		.sr_load(sr_load), .sr_value(sr_value)
	);

	bpi_bus_cycle bus_cycle (
		.CLK(CLK), .local_rst(local_rst), .cyc_start(cyc_start), .cyc_op(cyc_op),
		.cyc_addr(cyc_addr), .cyc_data(cyc_data), .bpi_busy(bpi_busy),
		.bpi_load_data(bpi_load_data), .bpi_data_from(bpi_data_from),
		.cyc_done(cyc_done), .cyc_rdata(cyc_rdata), .bpi_execute(bpi_execute),
		.bpi_op(bpi_op), .bpi_addr(bpi_addr), .bpi_data_to(bpi_data_to)
	);

	bpi_status status (
		.CLK(CLK), .local_rst(local_rst),
		.rbk_empty(rbk_empty), .rbk_full(rbk_full), .rbk_over(rbk_over), .rbk_under(rbk_under),
		.cmd_empty(cmd_empty), .cmd_full(cmd_full), .cmd_over(cmd_over), .cmd_under(cmd_under),
		.sr_load(sr_load), .sr_value(sr_value), .clr_sticky(clr_sticky),
		.bpi_status(bpi_status)
	);

endmodule

`default_nettype wire

// ==== bpi_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpi_ctrl_tb;
	import bpi_pkg::*;

	localparam int CMD_DEPTH = 2048;
	localparam int RBK_DEPTH = 2048;
	localparam int CW        = $clog2(RBK_DEPTH + 1);
	localparam int TIMEOUT   = 2000;	// Cycles allowed per wait

	logic            CLK = 1'b0;
	logic            local_rst;
	word_t           cmd_data;
	logic            cmd_we;
	logic            rbk_re;
	logic            bpi_enbl;
	logic            bpi_dsbl;
	word_t           rbk_data;
	logic [CW-1:0]   rbk_wrd_cnt;
	word_t           bpi_status;
	logic            bpi_busy;
	logic            bpi_load_data;
	word_t           bpi_data_from;
	logic            bpi_execute;
	bpi_op_e         bpi_op;
	addr_t           bpi_addr;
	word_t           bpi_data_to;
	logic            set_err;
	addr_t           erase_addr;
	word_t           prog_data [3];

	always #20 CLK = ~CLK;

	bpi_ctrl #(.CMD_DEPTH(CMD_DEPTH), .RBK_DEPTH(RBK_DEPTH)) dut (
		.CLK(CLK), .local_rst(local_rst), .cmd_data(cmd_data), .cmd_we(cmd_we),
		.rbk_re(rbk_re), .bpi_enbl(bpi_enbl), .bpi_dsbl(bpi_dsbl), .rbk_data(rbk_data),
		.rbk_wrd_cnt(rbk_wrd_cnt), .bpi_status(bpi_status), .bpi_busy(bpi_busy),
		.bpi_load_data(bpi_load_data), .bpi_data_from(bpi_data_from),
		.bpi_execute(bpi_execute), .bpi_op(bpi_op), .bpi_addr(bpi_addr),
		.bpi_data_to(bpi_data_to)
	);

	bpi_flash_model flash (
		.CLK(CLK), .bpi_execute(bpi_execute), .bpi_op(bpi_op), .bpi_addr(bpi_addr),
		.bpi_data_to(bpi_data_to), .set_err(set_err), .bpi_busy(bpi_busy),
		.bpi_load_data(bpi_load_data), .bpi_data_from(bpi_data_from), .erase_addr(erase_addr)
	);

	task automatic step();
		@(posedge CLK);
		#2;
	endtask

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		assert (got === exp)
		else
			fail_run($sformatf("error at %0t ns: %s expected %h, got %h", $time, name, exp, got));
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		assert (got === exp)
		else
			fail_run($sformatf("error at %0t ns: %s expected %h, got %h", $time, name, exp, got));
	endtask

	task automatic write_cmd(input word_t w);
		cmd_data = w;
		cmd_we   = 1'b1;
		step();
		cmd_we   = 1'b0;
	endtask

	task automatic send_op(input bpi_cmd_e op);
		write_cmd({11'h000, op});
	endtask

	// Base in bits 11:5 of the opcode word and offset in the next word
	task automatic load_address(input addr_t a);
		write_cmd({4'h0, a[22:16], CMD_LOAD_ADDR});
		write_cmd(a[15:0]);
	endtask

	task automatic program_word(input word_t d);
		send_op(CMD_PROGRAM);
		write_cmd(d);
	endtask

	task automatic pop_expect(input word_t exp);
		check_word("rbk_data", rbk_data, exp);
		rbk_re = 1'b1;
		step();
		rbk_re = 1'b0;
	endtask

	task automatic expect_bus_quiet(input int cycles);
		repeat (cycles)
		begin
			step();
			assert (!bpi_execute)
			else
				fail_run("a bus cycle started while parsing was disabled");
		end
	endtask

	task automatic wait_status_bit(input int idx, input logic val, input string what);
		int n;
		n = 0;
		while (bpi_status[idx] !== val && n < TIMEOUT)
		begin
			step();
			n++;
		end
		assert (bpi_status[idx] === val)
		else
			fail_run({"timeout waiting for ", what});
	endtask

	task automatic wait_rbk_count(input logic [CW-1:0] target);
		int n;
		n = 0;
		while (rbk_wrd_cnt !== target && n < TIMEOUT)
		begin
			step();
			n++;
		end
		assert (rbk_wrd_cnt === target)
		else
			fail_run("timeout waiting for words in the readback FIFO");
	endtask

	// A trailing read marks the end of everything queued before it
	task automatic sync_queue();
		send_op(CMD_READ_1);
		wait_rbk_count(1);
		rbk_re = 1'b1;
		step();
		rbk_re = 1'b0;
	endtask

	initial
	begin
		local_rst    = 1'b1;
		cmd_data     = '0;
		cmd_we       = 1'b0;
		rbk_re       = 1'b0;
		bpi_enbl     = 1'b0;
		bpi_dsbl     = 1'b0;
		set_err      = 1'b0;
		prog_data[0] = 16'hA5C3;
		prog_data[1] = 16'h0F1E;
		prog_data[2] = 16'h7B21;
		repeat (8) @(posedge CLK);
		#2;
		local_rst = 1'b0;
		step();
		check_word("bpi_status", bpi_status, 16'h8800);	// Both FIFOs empty

		////////////////////
		// Parsing starts disabled
		load_address(23'h05_0100);
		for (int i = 0; i < 3; i++)
			program_word(prog_data[i]);
		expect_bus_quiet(50);
		check_word("bpi_status[11]", {15'h0000, bpi_status[ST_CMD_EMPTY]}, 16'h0000);
		bpi_enbl = 1'b1;
		step();
		bpi_enbl = 1'b0;
		wait_status_bit(ST_CMD_EMPTY, 1'b1, "the command FIFO to drain");

		// Offset steps by one per read back
		load_address(23'h05_0100);
		for (int i = 0; i < 3; i++)
			send_op(CMD_READ_1);
		wait_rbk_count(3);
		for (int i = 0; i < 3; i++)
			pop_expect(prog_data[i]);
		check_word("rbk_wrd_cnt", 16'(rbk_wrd_cnt), 16'h0000);

		////////////////////
		// Main block erase
		load_address(23'h0A_1234);
		program_word(16'h2222);
		load_address(23'h0A_1234);
		send_op(CMD_READ_1);
		wait_rbk_count(1);
		pop_expect(16'h2222);
		load_address(23'h0A_1234);
		send_op(CMD_BLOCK_ERASE);
		load_address(23'h0A_1234);
		send_op(CMD_READ_1);
		wait_rbk_count(1);
		check_addr("erase_addr", erase_addr, 23'h0A_0000);	// 64K block base
		pop_expect(16'hFFFF);

		// Parameter block erase leaves the neighbouring 16K block alone
		load_address(23'h7F_9ABC);
		program_word(16'h3333);
		load_address(23'h7F_4ABC);
		program_word(16'h4444);
		load_address(23'h7F_9ABC);
		send_op(CMD_BLOCK_ERASE);
		load_address(23'h7F_9ABC);
		send_op(CMD_READ_1);
		load_address(23'h7F_4ABC);
		send_op(CMD_READ_1);
		wait_rbk_count(2);
		check_addr("erase_addr", erase_addr, 23'h7F_8000);	// 16K block base
		pop_expect(16'hFFFF);
		pop_expect(16'h4444);

		////////////////////
		// Status byte with a program error flagged by the PROM
		set_err = 1'b1;
		step();
		set_err = 1'b0;
		load_address(23'h05_0200);
		program_word(16'h5A5A);
		sync_queue();
		check_word("bpi_status[7:0]", {8'h00, bpi_status[7:0]}, 16'h0090);
		send_op(CMD_CLR_SR);
		send_op(CMD_READ_SR);
		sync_queue();
		check_word("bpi_status[7:0]", {8'h00, bpi_status[7:0]}, 16'h0080);

		// Disable holds off new commands until enabled again
		bpi_dsbl = 1'b1;
		step();
		bpi_dsbl = 1'b0;
		send_op(CMD_READ_SR);
		expect_bus_quiet(20);
		bpi_enbl = 1'b1;
		step();
		bpi_enbl = 1'b0;
		sync_queue();

		////////////////////
		// Readback underflow is sticky
		rbk_re = 1'b1;
		step();
		rbk_re = 1'b0;
		wait_status_bit(ST_RBK_UNDER, 1'b1, "the readback underflow bit");
		repeat (20) step();
		check_word("bpi_status[13]", {15'h0000, bpi_status[ST_RBK_UNDER]}, 16'h0001);
		send_op(CMD_CLR_STATUS);
		wait_status_bit(ST_RBK_UNDER, 1'b0, "the underflow bit to clear");
		check_word("bpi_status", bpi_status, 16'h8880);

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bpi_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpi_fifo #(
	parameter int DEPTH = 2048
) (
	input  wire                          CLK,
	input  wire                          local_rst,
	input  wire                          wr_en,
	input  wire bpi_pkg::word_t          wr_data,
	input  wire                          rd_en,
	output bpi_pkg::word_t               rd_data,
	output logic [$clog2(DEPTH+1)-1:0]   count,
	output logic                         empty,
	output logic                         full,
	output logic                         over,
	output logic                         under
);
	import bpi_pkg::*;

	localparam int PW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	word_t           mem [DEPTH];
	logic [PW-1:0]   wr_ptr;
	logic [PW-1:0]   rd_ptr;
	logic            do_wr;
	logic            do_rd;

	assign empty = (count == '0);
	assign full  = (count == CW'(DEPTH));
	assign do_wr = wr_en && !full;	// Rejected writes leave the FIFO alone
	assign do_rd = rd_en && !empty;
	assign rd_data = mem[rd_ptr];	// Show-ahead head word

	always_ff @(posedge CLK)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			over   <= 1'b0;
			under  <= 1'b0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Idle or both at once
			endcase
			over  <= wr_en && full;	// One-cycle error pulses
			under <= rd_en && empty;
		end
	end

endmodule

`default_nettype wire

// ==== bpi_flash_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpi_flash_model (
	input  wire                      CLK,
	input  wire                      bpi_execute,
	input  wire bpi_pkg::bpi_op_e    bpi_op,
	input  wire bpi_pkg::addr_t      bpi_addr,
	input  wire bpi_pkg::word_t      bpi_data_to,
	input  wire                      set_err,
	output logic                     bpi_busy,
	output logic                     bpi_load_data,
	output bpi_pkg::word_t           bpi_data_from,
	output bpi_pkg::addr_t           erase_addr
);
	import bpi_pkg::*;

	word_t      mem [addr_t];	// Missing entries read as erased
	integer     seed;
	logic       status_mode;	// Reads return the status register
	logic       err_flag;
	logic       prog_pend;
	logic       erase_pend;
	logic       read_pend;
	int         busy_cnt;
	word_t      read_word;
	logic       exec_s;
	bpi_op_e    op_s;
	addr_t      addr_s;
	word_t      data_s;
	logic       set_s;

	// 16K parameter blocks at the top, 64K main blocks below
	task automatic erase_block(input addr_t a);
		addr_t base;
		addr_t wa;
		int    size;
		size = (a > 23'h7EFFFF) ? 32'h0000_4000 : 32'h0001_0000;
		base = a & ~addr_t'(size - 1);
		for (int i = 0; i < size; i++)
		begin
			wa = base + addr_t'(i);
			if (mem.exists(wa))
				mem.delete(wa);
		end
	endtask

	task automatic write_word(input addr_t a, input word_t d);
		if (prog_pend)
		begin
			mem[a]      = d;	// Second cycle of a program
			prog_pend   = 1'b0;
			status_mode = 1'b1;
		end
		else if (erase_pend)
		begin
			if (d == FL_CONFIRM)
				erase_block(a);
			erase_pend  = 1'b0;
			status_mode = 1'b1;
		end
		else
			case (d)
				FL_READ_ARRAY:
					status_mode = 1'b0;
				FL_READ_SR:
					status_mode = 1'b1;
				FL_CLR_SR:
					err_flag = 1'b0;
				FL_ERASE:
				begin
					erase_pend = 1'b1;
					erase_addr = a;
				end
				FL_PROGRAM:
					prog_pend = 1'b1;
				default: ;
			endcase
	endtask

	initial
	begin
		seed          = 32'hceb6_69eb;
		bpi_busy      = 1'b0;
		bpi_load_data = 1'b0;
		bpi_data_from = '0;
		erase_addr    = '0;
		status_mode   = 1'b0;
		err_flag      = 1'b0;
		prog_pend     = 1'b0;
		erase_pend    = 1'b0;
		read_pend     = 1'b0;
		busy_cnt      = 0;
		read_word     = '0;
		forever
		begin
			@(posedge CLK);
			exec_s = bpi_execute;	// Values of the cycle just ended
			op_s   = bpi_op;
			addr_s = bpi_addr;
			data_s = bpi_data_to;
			set_s  = set_err;
			#2;
			bpi_load_data = 1'b0;
			if (set_s)
				err_flag = 1'b1;
			if (busy_cnt > 0)
			begin
				busy_cnt--;
				if (busy_cnt == 0)
				begin
					bpi_busy = 1'b0;
					if (read_pend)
					begin
						bpi_load_data = 1'b1;
						bpi_data_from = read_word;
						read_pend     = 1'b0;
					end
				end
			end
			if (exec_s)
			begin
				if (op_s == OP_READ)
				begin
					read_pend = 1'b1;
					if (status_mode)
						read_word = {8'h00, 8'h80 | (err_flag ? 8'h10 : 8'h00)};
					else
						read_word = mem.exists(addr_s) ? mem[addr_s] : 16'hFFFF;
				end
				else
					write_word(addr_s, data_s);
				bpi_busy = 1'b1;
				busy_cnt = 1 + int'($unsigned($random(seed)) % 6);	// 1 to 6 cycles
			end
		end
	end

endmodule

`default_nettype wire

// ==== bpi_pkg.sv ====
`default_nettype none

package bpi_pkg;

	typedef logic [15:0] word_t;	// Host and flash data word
	typedef logic [22:0] addr_t;	// Flash word address

	// Opcode in bits 4:0 of a command word
	typedef enum logic [4:0] {
		CMD_NOOP        = 5'h00,
		CMD_READ_1      = 5'h02,
		CMD_READ_SR     = 5'h06,
		CMD_CLR_SR      = 5'h09,
		CMD_BLOCK_ERASE = 5'h0A,
		CMD_PROGRAM     = 5'h0B,
		CMD_LOAD_ADDR   = 5'h17,	// Local, followed by offset word
		CMD_CLR_STATUS  = 5'h1C	// Local
	} bpi_cmd_e;

	typedef enum logic [1:0] {
		OP_WRITE = 2'b01,
		OP_READ  = 2'b10
	} bpi_op_e;

	////////////////////
	// PROM command set
	localparam word_t FL_READ_ARRAY = 16'h00FF;
	localparam word_t FL_READ_SR    = 16'h0070;
	localparam word_t FL_CLR_SR     = 16'h0050;
	localparam word_t FL_ERASE      = 16'h0020;
	localparam word_t FL_CONFIRM    = 16'h00D0;
	localparam word_t FL_PROGRAM    = 16'h0040;

	// Bank and block decoding
	localparam addr_t BANK_MASK         = 23'h780000;
	localparam addr_t PARAM_BLOCK_START = 23'h7F0000;	// 16K blocks from here up
	localparam addr_t PARAM_BLOCK_MASK  = 23'h7FC000;
	localparam addr_t MAIN_BLOCK_MASK   = 23'h7F0000;

	localparam int SR_READY_BIT = 7;
	localparam logic [7:0] ERASE_ERR_MASK = 8'h2A;
	localparam logic [7:0] PROG_ERR_MASK  = 8'h1A;

	////////////////////
	// Status word layout with the PROM status register in the low byte
	localparam int ST_RBK_EMPTY = 15;
	localparam int ST_RBK_FULL  = 14;
	localparam int ST_RBK_UNDER = 13;
	localparam int ST_RBK_OVER  = 12;
	localparam int ST_CMD_EMPTY = 11;
	localparam int ST_CMD_FULL  = 10;
	localparam int ST_CMD_UNDER = 9;
	localparam int ST_CMD_OVER  = 8;

endpackage

`default_nettype wire

// ==== bpi_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpi_sequencer (
	input  wire                          CLK,
	input  wire                          local_rst,
	input  wire                          seq_start,
	input  wire bpi_pkg::bpi_cmd_e       seq_cmd,
	input  wire bpi_pkg::addr_t          seq_addr,
	input  wire bpi_pkg::word_t          seq_data,
	input  wire                          cyc_done,
	input  wire bpi_pkg::word_t          cyc_rdata,
	output logic                         seq_done,
	output logic                         cyc_start,
	output bpi_pkg::bpi_op_e             cyc_op,
	output bpi_pkg::addr_t               cyc_addr,
	output bpi_pkg::word_t               cyc_data,
	output logic                         rbk_push,
	output bpi_pkg::word_t               rbk_wdata,
	output logic                         sr_load,
	output logic [7:0]                   sr_value
);
	import bpi_pkg::*;

	// Each bus cycle has an issue state and a wait state
	typedef enum logic [3:0] {
		S_IDLE,
		S_FIRST,
		S_FIRST_W,
		S_SECOND,
		S_SECOND_W,
		S_POLL_CMD,
		S_POLL_CMD_W,
		S_POLL_RD,
		S_POLL_RD_W,
		S_FINISH
	} seq_state_e;

	seq_state_e   state;
	bpi_cmd_e     cmd_q;
	addr_t        addr_q;
	word_t        data_q;
	addr_t        bank_addr;
	addr_t        block_addr;

	assign bank_addr  = addr_q & BANK_MASK;
	assign block_addr = (addr_q >= PARAM_BLOCK_START) ? (addr_q & PARAM_BLOCK_MASK)
		: (addr_q & MAIN_BLOCK_MASK);	// 16K parameter vs 64K main blocks

	assign cyc_start = (state == S_FIRST) || (state == S_SECOND) ||
		(state == S_POLL_CMD) || (state == S_POLL_RD);
	assign seq_done  = (state == S_FINISH);

	////////////////////
	// Bus cycle contents per step
	always_comb
	begin
		cyc_op   = OP_WRITE;
		cyc_addr = bank_addr;
		cyc_data = FL_READ_SR;	// Also the poll setup write
		case (state)
			S_FIRST, S_FIRST_W:
				case (cmd_q)
					CMD_READ_1:
						cyc_data = FL_READ_ARRAY;
					CMD_CLR_SR:
						cyc_data = FL_CLR_SR;
					CMD_BLOCK_ERASE:
					begin
						cyc_addr = block_addr;
						cyc_data = FL_ERASE;
					end
					CMD_PROGRAM:
					begin
						cyc_addr = addr_q;
						cyc_data = FL_PROGRAM;
					end
					default: ;
				endcase
			S_SECOND, S_SECOND_W:
				case (cmd_q)
					CMD_READ_1:
					begin
						cyc_op   = OP_READ;
						cyc_addr = addr_q;
					end
					CMD_BLOCK_ERASE:
					begin
						cyc_addr = block_addr;
						cyc_data = FL_CONFIRM;
					end
					CMD_PROGRAM:
					begin
						cyc_addr = addr_q;
						cyc_data = data_q;
					end
					default:
						cyc_op = OP_READ;	// Status register at bank
				endcase
			S_POLL_RD, S_POLL_RD_W:
				cyc_op = OP_READ;
			default: ;
		endcase
	end

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			state    <= S_IDLE;
			cmd_q    <= CMD_NOOP;
			rbk_push <= 1'b0;
			sr_load  <= 1'b0;
		end
		else
		begin
			rbk_push <= 1'b0;
			sr_load  <= 1'b0;
			case (state)
				S_IDLE:
					if (seq_start)
					begin
						cmd_q <= seq_cmd;
						case (seq_cmd)
							CMD_READ_1, CMD_READ_SR, CMD_CLR_SR, CMD_BLOCK_ERASE, CMD_PROGRAM:
								state <= S_FIRST;
							default:
								state <= S_FINISH;
						endcase
					end
				S_FIRST:
					state <= S_FIRST_W;
				S_FIRST_W:
					if (cyc_done)
						state <= (cmd_q == CMD_CLR_SR) ? S_FINISH : S_SECOND;
				S_SECOND:
					state <= S_SECOND_W;
				S_SECOND_W:
					if (cyc_done)
					begin
						rbk_push <= (cmd_q == CMD_READ_1);
						sr_load  <= (cmd_q == CMD_READ_SR);
						if (cmd_q == CMD_BLOCK_ERASE || cmd_q == CMD_PROGRAM)
							state <= S_POLL_CMD;
						else
							state <= S_FINISH;
					end
				S_POLL_CMD:
					state <= S_POLL_CMD_W;
				S_POLL_CMD_W:
					if (cyc_done)
						state <= S_POLL_RD;
				S_POLL_RD:
					state <= S_POLL_RD_W;
				S_POLL_RD_W:
					if (cyc_done)
					begin
						sr_load <= 1'b1;	// Every poll updates the status byte
						if (cyc_rdata[SR_READY_BIT])
							state <= S_FINISH;
						else
							state <= S_POLL_RD;
					end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (state == S_IDLE && seq_start)
		begin
			addr_q <= seq_addr;
			data_q <= seq_data;
		end
		if (cyc_done)
		begin
			rbk_wdata <= cyc_rdata;
			sr_value  <= cyc_rdata[7:0];
		end
	end

endmodule

`default_nettype wire

// ==== bpi_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpi_status (
	input  wire                    CLK,
	input  wire                    local_rst,
	input  wire                    rbk_empty,
	input  wire                    rbk_full,
	input  wire                    rbk_over,
	input  wire                    rbk_under,
	input  wire                    cmd_empty,
	input  wire                    cmd_full,
	input  wire                    cmd_over,
	input  wire                    cmd_under,
	input  wire                    sr_load,
	input  wire [7:0]              sr_value,
	input  wire                    clr_sticky,
	output bpi_pkg::word_t         bpi_status
);
	import bpi_pkg::*;

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
			bpi_status <= '0;
		else
		begin
			// Live FIFO flags
			bpi_status[ST_RBK_EMPTY] <= rbk_empty;
			bpi_status[ST_RBK_FULL]  <= rbk_full;
			bpi_status[ST_CMD_EMPTY] <= cmd_empty;
			bpi_status[ST_CMD_FULL]  <= cmd_full;

			// Sticky errors where a new pulse beats a clear in the same cycle
			bpi_status[ST_RBK_UNDER] <= rbk_under || (!clr_sticky && bpi_status[ST_RBK_UNDER]);
			bpi_status[ST_RBK_OVER]  <= rbk_over || (!clr_sticky && bpi_status[ST_RBK_OVER]);
			bpi_status[ST_CMD_UNDER] <= cmd_under || (!clr_sticky && bpi_status[ST_CMD_UNDER]);
			bpi_status[ST_CMD_OVER]  <= cmd_over || (!clr_sticky && bpi_status[ST_CMD_OVER]);

			if (sr_load)
				bpi_status[7:0] <= sr_value;	// Last PROM status byte
		end
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
bpi_pkg.sv
bpi_fifo.sv
bpi_cmd_parser.sv
bpi_sequencer.sv
bpi_bus_cycle.sv
bpi_status.sv
bpi_ctrl.sv
bpi_flash_model.sv
bpi_ctrl_tb.sv
